/* hw/cachePkg.sv */
`default_nettype none

package cachePkg;

  // Address and data widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 16;

  // Address split: tag | set index | word offset
  localparam int TAG_W = 7;
  localparam int SET_W = 6;
  localparam int OFF_W = 3;

  // Cache geometry, two ways per set
  localparam int NUM_SETS        = 64;
  localparam int WORDS_PER_BLOCK = 8;

  // Backing memory timing, request to data pulse
  localparam int MEM_LATENCY = 4;

  // Memory word at address A is A ^ MEM_PATTERN
  localparam logic [DATA_W-1:0] MEM_PATTERN = 16'hA5C3;

  // Miss handler states
  typedef enum logic [1:0] {
    IDLE,       // No fill in progress
    REQUEST,    // Memory request for the current word
    WAIT_DATA,  // Waiting for the data pulse
    WRITE_TAG   // Block complete, validate the tag
  } fillState_e;

endpackage

`default_nettype wire

/* hw/dataArray.sv */
`default_nettype none
`timescale 1ns/10ps

module dataArray import cachePkg::*; (
  input  logic              clk,
  input  logic              writeEn,
  input  logic              way,
  input  logic [SET_W-1:0]  setIndex,
  input  logic [OFF_W-1:0]  wordOffset,
  input  logic [DATA_W-1:0] dataIn,
  output logic [DATA_W-1:0] dataOut
);

  // Word address is {way, set, offset}, so way 0 sits in the low half
  logic [SET_W+OFF_W:0] wordAddr;

  // Two ways of 64 sets of 8 words
  logic [DATA_W-1:0] words [2*NUM_SETS*WORDS_PER_BLOCK];

  assign wordAddr = {way, setIndex, wordOffset};

  // Single word write, used for both fills and write hits
  always_ff @(posedge clk) begin
    if (writeEn) begin
      words[wordAddr] <= dataIn;
    end
  end

  // Read path is combinational so a hit returns data in the same cycle
  assign dataOut = words[wordAddr];

endmodule

`default_nettype wire

/* hw/metaDataArray.sv */
`default_nettype none
`timescale 1ns/10ps

module metaDataArray import cachePkg::*; (
  input  logic             clk,
  input  logic             rstN,
  input  logic [SET_W-1:0] setIndex,
  input  logic [TAG_W-1:0] tagIn,
  input  logic             writeTag,
  input  logic             writeWay,
  input  logic             touch,
  input  logic             touchWay,
  output logic             valid0,
  output logic             valid1,
  output logic [TAG_W-1:0] tag0,
  output logic [TAG_W-1:0] tag1,
  output logic             lruWay
);

  // Per set state, one bit each
  logic [NUM_SETS-1:0] validWay0;
  logic [NUM_SETS-1:0] validWay1;
  logic [NUM_SETS-1:0] lruBits;   // Names the least recently used way

  // Tag storage per way
  logic [TAG_W-1:0] tagsWay0 [NUM_SETS];
  logic [TAG_W-1:0] tagsWay1 [NUM_SETS];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      validWay0 <= '0;
      validWay1 <= '0;
      lruBits   <= '0;
    end else begin
      // A tag write always makes the line valid
      if (writeTag) begin
        if (writeWay) begin
          validWay1[setIndex] <= 1'b1;
        end else begin
          validWay0[setIndex] <= 1'b1;
        end
      end
      if (touch) begin
        lruBits[setIndex] <= ~touchWay;  // Other way becomes LRU
      end
    end
  end

  always_ff @(posedge clk) begin
    if (writeTag) begin
      if (writeWay) begin
        tagsWay1[setIndex] <= tagIn;
      end else begin
        tagsWay0[setIndex] <= tagIn;
      end
    end
  end

  // Lookup of the addressed set
  assign valid0 = validWay0[setIndex];
  assign valid1 = validWay1[setIndex];
  assign tag0   = tagsWay0[setIndex];
  assign tag1   = tagsWay1[setIndex];
  assign lruWay = lruBits[setIndex];

endmodule

`default_nettype wire

/* hw/cacheFillFsm.sv */
`default_nettype none
`timescale 1ns/10ps

module cacheFillFsm import cachePkg::*; (
  input  logic             clk,
  input  logic             rstN,
  input  logic             missDetected,
  input  logic             memDataValid,
  output logic             busy,
  output logic             memRequest,
  output logic [OFF_W-1:0] fillWordOffset,
  output logic             writeDataArray,
  output logic             writeTagArray
);

  fillState_e state;
  fillState_e stateNext;

  // Word being fetched within the block
  logic [OFF_W-1:0] wordCnt;
  logic             lastWord;

  assign lastWord = (wordCnt == OFF_W'(WORDS_PER_BLOCK - 1));

  always_comb begin
    stateNext = state;
    case (state)
      IDLE: begin
        if (missDetected) begin
          stateNext = REQUEST;
        end
      end
      REQUEST: begin
        stateNext = WAIT_DATA;  // Request is a single cycle pulse
      end
      WAIT_DATA: begin
        // Data pulse ends the round, either next word or tag write
        if (memDataValid) begin
          stateNext = lastWord ? WRITE_TAG : REQUEST;
        end
      end
      WRITE_TAG: begin
        stateNext = IDLE;
      end
      default: begin
        stateNext = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state   <= IDLE;
      wordCnt <= '0;
    end else begin
      state <= stateNext;
      // Advances per stored word, wraps back to 0 after the last one
      if (writeDataArray) begin
        wordCnt <= wordCnt + 1'b1;
      end
    end
  end

  // Stall starts in the miss cycle itself, before the FSM leaves IDLE
  assign busy = (state != IDLE) || missDetected;

  assign memRequest     = (state == REQUEST);
  assign writeDataArray = (state == WAIT_DATA) && memDataValid;
  assign writeTagArray  = (state == WRITE_TAG);
  assign fillWordOffset = wordCnt;

endmodule

`default_nettype wire

/* hw/cache.sv */
`default_nettype none
`timescale 1ns/10ps

module cache import cachePkg::*; (
  input  logic              clk,
  input  logic              rstN,
  input  logic [ADDR_W-1:0] address,
  input  logic [DATA_W-1:0] dataIn,
  input  logic              readEn,
  input  logic              writeEn,
  input  logic [DATA_W-1:0] memData,
  input  logic              memDataValid,
  output logic              stall,
  output logic [DATA_W-1:0] dataOut,
  output logic [ADDR_W-1:0] memAddress,
  output logic              memRequest
);

  // Address fields
  logic [TAG_W-1:0] tagBits;
  logic [SET_W-1:0] setBits;
  logic [OFF_W-1:0] offsetBits;

  // Metadata lookup
  logic             valid0;
  logic             valid1;
  logic [TAG_W-1:0] tag0;
  logic [TAG_W-1:0] tag1;
  logic             lruWay;

  // Hit and miss
  logic hit0;
  logic hit1;
  logic hitWay;
  logic victimWay;
  logic accessEn;
  logic accessDone;
  logic missDetected;

  // Fill FSM
  logic             busy;
  logic [OFF_W-1:0] fillWordOffset;
  logic             writeDataArray;
  logic             writeTagArray;

  // Data array steering
  logic              dataWrite;
  logic              arrayWay;
  logic [OFF_W-1:0]  arrayOffset;
  logic [DATA_W-1:0] arrayDataIn;

  assign tagBits    = address[ADDR_W-1 -: TAG_W];
  assign setBits    = address[OFF_W +: SET_W];
  assign offsetBits = address[OFF_W-1:0];

  // A tag match only counts on a valid way
  assign hit0   = valid0 && (tag0 == tagBits);
  assign hit1   = valid1 && (tag1 == tagBits);
  assign hitWay = hit1;

  assign accessEn     = readEn || writeEn;
  assign missDetected = accessEn && !hit0 && !hit1;
  assign accessDone   = accessEn && !stall;

  // Invalid way first (way 0 before way 1), else the LRU way
  assign victimWay = !valid0 ? 1'b0 :
                     !valid1 ? 1'b1 : lruWay;

  assign stall = busy;

  // While stalled the data array belongs to the fill
  assign arrayWay    = stall ? victimWay : hitWay;
  assign arrayOffset = stall ? fillWordOffset : offsetBits;
  assign arrayDataIn = stall ? memData : dataIn;
  assign dataWrite   = writeDataArray || (writeEn && !stall);  // Fill word or write hit

  assign memAddress = {tagBits, setBits, fillWordOffset};  // Block address, word from the FSM

  dataArray dataStore (
    .clk       (clk),
    .writeEn   (dataWrite),
    .way       (arrayWay),
    .setIndex  (setBits),
    .wordOffset(arrayOffset),
    .dataIn    (arrayDataIn),
    .dataOut   (dataOut)
  );

  metaDataArray metaStore (
    .clk     (clk),
    .rstN    (rstN),
    .setIndex(setBits),
    .tagIn   (tagBits),
    .writeTag(writeTagArray),
    .writeWay(victimWay),
    .touch   (accessDone),
    .touchWay(hitWay),
    .valid0  (valid0),
    .valid1  (valid1),
    .tag0    (tag0),
    .tag1    (tag1),
    .lruWay  (lruWay)
  );

  cacheFillFsm fillFsm (
    .clk           (clk),
    .rstN          (rstN),
    .missDetected  (missDetected),
    .memDataValid  (memDataValid),
    .busy          (busy),
    .memRequest    (memRequest),
    .fillWordOffset(fillWordOffset),
    .writeDataArray(writeDataArray),
    .writeTagArray (writeTagArray)
  );

endmodule

`default_nettype wire

/* hw/mainMemory.sv */
`default_nettype none
`timescale 1ns/10ps

module mainMemory import cachePkg::*; (
  input  logic              clk,
  input  logic              rstN,
  input  logic              memRequest,
  input  logic [ADDR_W-1:0] memAddress,
  output logic [DATA_W-1:0] memData,
  output logic              memDataValid
);

  typedef logic [$clog2(MEM_LATENCY+1)-1:0] latCount_t;

  latCount_t         latencyCnt;
  logic              pending;     // Request in flight
  logic [ADDR_W-1:0] reqAddress;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pending      <= 1'b0;
      latencyCnt   <= '0;
      memDataValid <= 1'b0;
    end else begin
      memDataValid <= 1'b0;
      if (!pending) begin
        if (memRequest) begin
          pending    <= 1'b1;
          latencyCnt <= latCount_t'(MEM_LATENCY - 1);
        end
      end else if (latencyCnt == latCount_t'(1)) begin
        pending      <= 1'b0;
        memDataValid <= 1'b1;  // Lands MEM_LATENCY cycles after the request
      end else begin
        latencyCnt <= latencyCnt - 1'b1;
      end
    end
  end

  // New requests are ignored while one is pending
  always_ff @(posedge clk) begin
    if (memRequest && !pending) begin
      reqAddress <= memAddress;
    end
  end

  assign memData = reqAddress ^ MEM_PATTERN;

endmodule

`default_nettype wire

/* hw/cacheSystem.sv */
`default_nettype none
`timescale 1ns/10ps

module cacheSystem import cachePkg::*; (
  input  logic              clk,
  input  logic              rstN,
  input  logic [ADDR_W-1:0] address,
  input  logic [DATA_W-1:0] dataIn,
  input  logic              readEn,
  input  logic              writeEn,
  output logic [DATA_W-1:0] dataOut,
  output logic              stall
);

  // Cache to memory link
  logic [ADDR_W-1:0] memAddress;
  logic              memRequest;
  logic [DATA_W-1:0] memData;
  logic              memDataValid;

  cache cacheCore (
    .clk         (clk),
    .rstN        (rstN),
    .address     (address),
    .dataIn      (dataIn),
    .readEn      (readEn),
    .writeEn     (writeEn),
    .memData     (memData),
    .memDataValid(memDataValid),
    .stall       (stall),
    .dataOut     (dataOut),
    .memAddress  (memAddress),
    .memRequest  (memRequest)
  );

  mainMemory mainMem (
    .clk         (clk),
    .rstN        (rstN),
    .memRequest  (memRequest),
    .memAddress  (memAddress),
    .memData     (memData),
    .memDataValid(memDataValid)
  );

endmodule

`default_nettype wire

/* testbench/cacheSystem_assert.sv */
`default_nettype none
`timescale 1ns/10ps

module cacheAssert import cachePkg::*; (
  input logic       clk,
  input logic       rstN,
  input logic       stall,
  input logic       memRequest,
  input logic       memDataValid,
  input logic       writeTagArray,
  input fillState_e fillState
);

  int failCount = 0;  // Failed assertions so far

  // Each request gets its word back while the FSM still waits for it
  property dataPulseAfterRequest;
    @(posedge clk) disable iff (!rstN)
      memRequest |-> ##MEM_LATENCY (memDataValid && (fillState == WAIT_DATA));
  endproperty

  // Tag write ends the fill and the retried access then hits
  property stallDropsAfterTag;
    @(posedge clk) disable iff (!rstN)
      writeTagArray |=> !stall;
  endproperty

  property stallLowAfterReset;
    @(posedge clk) !rstN |=> !stall;
  endproperty

  assert property (dataPulseAfterRequest) else begin
    $error("memDataValid missing MEM_LATENCY cycles after memRequest");
    failCount = failCount + 1;
  end

  assert property (stallDropsAfterTag) else begin
    $error("stall still high in the cycle after the tag write");
    failCount = failCount + 1;
  end

  assert property (stallLowAfterReset) else begin
    $error("stall high right after a reset cycle");
    failCount = failCount + 1;
  end

endmodule

bind cache cacheAssert assertChecks (
  .clk          (clk),
  .rstN         (rstN),
  .stall        (stall),
  .memRequest   (memRequest),
  .memDataValid (memDataValid),
  .writeTagArray(writeTagArray),
  .fillState    (fillFsm.state)
);

`default_nettype wire

/* testbench/cacheSystemTb.sv */
`default_nettype none
`timescale 1ns/10ps

module cacheSystemTb import cachePkg::*; ();

  logic              clk = 1'b0;
  logic              rstN;
  logic [ADDR_W-1:0] address;
  logic [DATA_W-1:0] dataIn;
  logic              readEn;
  logic              writeEn;
  logic [DATA_W-1:0] dataOut;
  logic              stall;

  integer seed = 45;
  int     waitLimit = 100;  // Cycles one access may stay stalled

  // Shadow copy of the cache contents
  logic              mValid [2][NUM_SETS];
  logic [TAG_W-1:0]  mTag   [2][NUM_SETS];
  logic              mLru   [NUM_SETS];
  logic [DATA_W-1:0] mWords [2][NUM_SETS][WORDS_PER_BLOCK];
  logic              modelMiss;  // Last modelled access missed

  cacheSystem DUT (
    .clk    (clk),
    .rstN   (rstN),
    .address(address),
    .dataIn (dataIn),
    .readEn (readEn),
    .writeEn(writeEn),
    .dataOut(dataOut),
    .stall  (stall)
  );

  always #10 clk = ~clk;

  function automatic logic [ADDR_W-1:0] makeAddr(input logic [TAG_W-1:0] tag,
      input logic [SET_W-1:0] setIdx, input logic [OFF_W-1:0] off);
    return {tag, setIdx, off};
  endfunction

  // Expected read word; also updates the shadow state like the cache would
  function automatic logic [DATA_W-1:0] modelCache(input logic isWrite,
      input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
    logic [TAG_W-1:0] tag;
    logic [SET_W-1:0] setIdx;
    logic [OFF_W-1:0] off;
    logic             way;
    int               i;
    tag    = addr[ADDR_W-1 -: TAG_W];
    setIdx = addr[OFF_W +: SET_W];
    off    = addr[OFF_W-1:0];
    modelMiss = 1'b0;
    if (mValid[0][setIdx] && mTag[0][setIdx] == tag) begin
      way = 1'b0;
    end else if (mValid[1][setIdx] && mTag[1][setIdx] == tag) begin
      way = 1'b1;
    end else begin
      modelMiss = 1'b1;
      // Empty way first, otherwise the LRU way; old words are dropped
      if (!mValid[0][setIdx]) begin
        way = 1'b0;
      end else if (!mValid[1][setIdx]) begin
        way = 1'b1;
      end else begin
        way = mLru[setIdx];
      end
      for (i = 0; i < WORDS_PER_BLOCK; i++) begin
        mWords[way][setIdx][i] = makeAddr(tag, setIdx, OFF_W'(i)) ^ MEM_PATTERN;
      end
      mValid[way][setIdx] = 1'b1;
      mTag[way][setIdx]   = tag;
    end
    if (isWrite) begin
      mWords[way][setIdx][off] = wdata;
    end
    mLru[setIdx] = ~way;
    return mWords[way][setIdx][off];
  endfunction

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic checkData(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
      input string what);
    if (got !== exp) begin
      abortRun($sformatf("[FAIL] %0t: %s returned %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic checkStall(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abortRun($sformatf("[FAIL] %0t: %s, stall was %b, expected %b", $time, what, got, exp));
    end
  endtask

  // Starts 1 ns after a rising edge and returns 1 ns after the completing edge
  task automatic doAccess(input logic isWrite, input logic [ADDR_W-1:0] addr,
      input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] got,
      output logic stalled);
    int waitCycles;
    address    = addr;
    dataIn     = wdata;
    readEn     = !isWrite;
    writeEn    = isWrite;
    stalled    = 1'b0;
    waitCycles = 0;
    @(negedge clk);
    while (stall) begin
      stalled = 1'b1;
      waitCycles++;
      if (waitCycles >= waitLimit) begin
        abortRun($sformatf("Timed out after %0d cycles waiting for stall to fall on address %h",
                           waitCycles, addr));
      end
      @(negedge clk);
    end
    got = dataOut;  // Stable mid cycle
    @(posedge clk);
    #1;
    readEn  = 1'b0;
    writeEn = 1'b0;
  endtask

  task automatic accessCheck(input logic isWrite, input logic [ADDR_W-1:0] addr,
      input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] got,
      output logic stalled);
    logic [DATA_W-1:0] expWord;
    logic              expMiss;
    expWord = modelCache(isWrite, addr, wdata);
    expMiss = modelMiss;
    doAccess(isWrite, addr, wdata, got, stalled);
    checkStall(stalled, expMiss, $sformatf("access to %h", addr));
    if (!isWrite) begin
      checkData(got, expWord, $sformatf("read of %h", addr));
    end
    if (DUT.cacheCore.assertChecks.failCount != 0) begin
      abortRun("A bound assertion on the cache failed");
    end
  endtask

  initial begin
    logic [DATA_W-1:0] got;
    logic              stalled;
    logic [ADDR_W-1:0] addrA;
    logic [ADDR_W-1:0] addrB;
    logic              isWrite;
    int                n;
    rstN    = 1'b0;
    address = '0;
    dataIn  = '0;
    readEn  = 1'b0;
    writeEn = 1'b0;
    for (n = 0; n < NUM_SETS; n++) begin
      mValid[0][n] = 1'b0;
      mValid[1][n] = 1'b0;
      mLru[n]      = 1'b0;
    end
    repeat (2) @(posedge clk);
    #1;
    rstN = 1'b1;
    @(negedge clk);
    checkStall(stall, 1'b0, "idle cycle after reset");
    @(posedge clk);
    #1;

    // Cold read fills the block
    addrA = makeAddr(7'h11, 6'h05, 3'd3);
    accessCheck(1'b0, addrA, '0, got, stalled);
    checkStall(stalled, 1'b1, "first read");
    checkData(got, addrA ^ MEM_PATTERN, "first read");

    // Neighbour word in the same block
    addrB = makeAddr(7'h11, 6'h05, 3'd6);
    accessCheck(1'b0, addrB, '0, got, stalled);
    checkStall(stalled, 1'b0, "read in filled block");
    checkData(got, addrB ^ MEM_PATTERN, "read in filled block");

    // Write hit, then read back
    accessCheck(1'b1, addrA, 16'hBEEF, got, stalled);
    accessCheck(1'b0, addrA, '0, got, stalled);
    checkStall(stalled, 1'b0, "read after write hit");
    checkData(got, 16'hBEEF, "read after write hit");

    // Write miss allocates the block first
    addrB = makeAddr(7'h22, 6'h0A, 3'd1);
    accessCheck(1'b1, addrB, 16'h1357, got, stalled);
    checkStall(stalled, 1'b1, "write miss");
    accessCheck(1'b0, addrB, '0, got, stalled);
    checkData(got, 16'h1357, "read after write miss");
    accessCheck(1'b0, makeAddr(7'h22, 6'h0A, 3'd4), '0, got, stalled);
    checkData(got, makeAddr(7'h22, 6'h0A, 3'd4) ^ MEM_PATTERN, "rest of allocated block");

    // Two tags share set 0x12, a third one evicts the LRU tag
    addrA = makeAddr(7'h03, 6'h12, 3'd2);
    addrB = makeAddr(7'h04, 6'h12, 3'd0);
    accessCheck(1'b0, addrA, '0, got, stalled);
    accessCheck(1'b1, addrA, 16'hCAFE, got, stalled);
    accessCheck(1'b0, addrB, '0, got, stalled);
    accessCheck(1'b0, addrA, '0, got, stalled);
    checkStall(stalled, 1'b0, "first tag still resident");
    checkData(got, 16'hCAFE, "first tag still resident");
    accessCheck(1'b0, makeAddr(7'h04, 6'h12, 3'd1), '0, got, stalled);
    checkStall(stalled, 1'b0, "second tag still resident");
    accessCheck(1'b0, makeAddr(7'h05, 6'h12, 3'd0), '0, got, stalled);
    checkStall(stalled, 1'b1, "third tag");
    accessCheck(1'b0, addrB, '0, got, stalled);
    checkStall(stalled, 1'b0, "survivor after eviction");
    accessCheck(1'b0, addrA, '0, got, stalled);
    checkStall(stalled, 1'b1, "evicted tag");
    checkData(got, addrA ^ MEM_PATTERN, "evicted tag loses its write");

    // Random mix over tags 0 to 3 and sets 0 and 1
    for (n = 0; n < 300; n++) begin
      addrA   = 16'($random(seed)) & 16'h060F;
      isWrite = ($random(seed) & 1) != 0;
      accessCheck(isWrite, addrA, 16'($random(seed)), got, stalled);
    end

    if (DUT.cacheCore.assertChecks.failCount == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      abortRun("A bound assertion on the cache failed");
    end
  end

endmodule

`default_nettype wire

/* list.f */
hw/cachePkg.sv
hw/dataArray.sv
hw/metaDataArray.sv
hw/cacheFillFsm.sv
hw/cache.sv
hw/mainMemory.sv
hw/cacheSystem.sv
testbench/cacheSystem_assert.sv
testbench/cacheSystemTb.sv

/* Bender.yml */
package:
  name: cache_system

sources:
  - files:
      - hw/cachePkg.sv
      - hw/dataArray.sv
      - hw/metaDataArray.sv
      - hw/cacheFillFsm.sv
      - hw/cache.sv
      - hw/mainMemory.sv
      - hw/cacheSystem.sv
  - target: test
    files:
      - testbench/cacheSystem_assert.sv
      - testbench/cacheSystemTb.sv
